//--- design/aes_cfg.svh
`ifndef AES_CFG_SVH
`define AES_CFG_SVH

// Block and key width, AES-128 only
`define AES_BLOCK_W 128

// One state column
`define AES_WORD_W 32

// Number of cipher rounds for a 128-bit key
`define AES_ROUNDS 10

// Each round stage is two register levels deep
`define AES_STAGE_CYC 2

// Whitening register plus all round stages
`define AES_LATENCY (1 + `AES_ROUNDS * `AES_STAGE_CYC)

`endif

//--- design/aes_pkg.sv
`default_nettype none

package aesPkg;

    `include "aes_cfg.svh"

    //////////////////////////////
    // Types
    //////////////////////////////

    // One column of the state, first row in the top byte
    typedef logic [`AES_WORD_W-1:0] aesWord_t;

    // Index 0 is the first column, in the top bits of the vector
    typedef aesWord_t [0:`AES_BLOCK_W/`AES_WORD_W-1] aesBlock_t;

    // What moves from one round stage to the next
    typedef struct packed {
        logic      valid;
        aesBlock_t state;
    } aesStage_t;

    //////////////////////////////
    // Forward S-box
    //////////////////////////////

    // Entry 0 sits in the top byte, one row of 16 entries per line
    localparam logic [0:255][7:0] sBox = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    //////////////////////////////
    // Byte helpers
    //////////////////////////////

    function automatic logic [7:0] subByte(input logic [7:0] b);
        return sBox[b];
    endfunction

    // Multiply by x modulo x^8 + x^4 + x^3 + x + 1
    function automatic logic [7:0] xTime(input logic [7:0] b);
        logic [7:0] shifted;
        shifted = {b[6:0], 1'b0};
        if (b[7])
        begin
            shifted = shifted ^ 8'h1b;
        end
        return shifted;
    endfunction

    // Round constant for rounds 1 to 10, i.e. x^(idx-1)
    // 01 02 04 ... 80 then wraps to 1b and 36
    function automatic logic [7:0] rcon(input int unsigned idx);
        logic [7:0] value;
        value = 8'h01;
        for (int unsigned i = 1; i < idx; i++)
        begin
            value = xTime(value);
        end
        return value;
    endfunction

endpackage

`default_nettype wire

//--- design/aes_key_stage.sv
`timescale 1ns/10ps
`default_nettype none

module aes_key_stage
#(
    parameter int unsigned roundIdx = 1
)
(
    input  logic              clk,
    input  aesPkg::aesBlock_t prevKey,
    output aesPkg::aesBlock_t roundKey,
    output aesPkg::aesBlock_t nextKey
);

    import aesPkg::*;

    localparam logic [7:0] roundConst = rcon(roundIdx);

    aesBlock_t partialComb;
    aesBlock_t partialReg;
    aesWord_t  rotWord;
    aesWord_t  subRotReg;

    //////////////////////////////
    // Cycle one
    //////////////////////////////

    // Running XOR of the old words, round constant folded into the first
    assign partialComb[0] = prevKey[0] ^ {roundConst, 24'h000000};
    assign partialComb[1] = partialComb[0] ^ prevKey[1];
    assign partialComb[2] = partialComb[1] ^ prevKey[2];
    assign partialComb[3] = partialComb[2] ^ prevKey[3];

    // RotWord on the last column
    assign rotWord = {prevKey[3][23:0], prevKey[3][31:24]};

    always_ff @(posedge clk)
    begin
        partialReg <= partialComb;
    end

    // SubWord of the rotated column, one lookup per byte
    always_ff @(posedge clk)
    begin
        for (int b = 0; b < 4; b++)
        begin
            subRotReg[8*b +: 8] <= subByte(rotWord[8*b +: 8]);
        end
    end

    //////////////////////////////
    // Cycle two
    //////////////////////////////

    // Every new word gets the same substituted column
    always_comb
    begin
        for (int w = 0; w < 4; w++)
        begin
            roundKey[w] = partialReg[w] ^ subRotReg;
        end
    end

    // Registered copy feeds the next key stage
    always_ff @(posedge clk)
    begin
        nextKey <= roundKey;
    end

endmodule

`default_nettype wire

//--- design/aes_round_stage.sv
`timescale 1ns/10ps
`default_nettype none

module aes_round_stage
#(
    parameter bit finalRound = 1'b0
)
(
    input  logic              clk,
    input  logic              COUNTER,
    input  aesPkg::aesStage_t stageIn,
    input  aesPkg::aesBlock_t roundKey,
    output aesPkg::aesStage_t stageOut
);

    import aesPkg::*;

    // Byte n is row n%4 of column n/4
    logic [7:0] subComb [16];
    logic [7:0] subReg [16];
    logic [7:0] dblReg [16];

    aesBlock_t  mixed;
    aesBlock_t  stateReg;
    logic       validMid;
    logic       validOut;

    //////////////////////////////
    // Cycle one, SubBytes
    //////////////////////////////

    always_comb
    begin
        for (int n = 0; n < 16; n++)
        begin
            subComb[n] = subByte(stageIn.state[n/4][8*(3-n%4) +: 8]);
        end
    end

    // Doubled bytes are taken here so cycle two is XOR only
    always_ff @(posedge clk)
    begin
        for (int n = 0; n < 16; n++)
        begin
            subReg[n] <= subComb[n];
            dblReg[n] <= xTime(subComb[n]);
        end
    end

    //////////////////////////////
    // Cycle two
    //////////////////////////////

    always_comb
    begin
        logic [7:0] a [4];
        logic [7:0] d [4];
        logic [7:0] outByte;
        for (int c = 0; c < 4; c++)
        begin
            // ShiftRows, row r of column c comes from column c+r
            for (int r = 0; r < 4; r++)
            begin
                a[r] = subReg[4*((c+r)%4) + r];
                d[r] = dblReg[4*((c+r)%4) + r];
            end
            for (int r = 0; r < 4; r++)
            begin
                if (finalRound)
                begin
                    outByte = a[r];
                end
                else
                begin
                    // 2*a[r] ^ 3*a[r+1] ^ a[r+2] ^ a[r+3]
                    outByte = d[r] ^ d[(r+1)%4] ^ a[(r+1)%4] ^ a[(r+2)%4]
                              ^ a[(r+3)%4];
                end
                mixed[c][8*(3-r) +: 8] = outByte ^ roundKey[c][8*(3-r) +: 8];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        stateReg <= mixed;
    end

    // Valid strobe, two levels to match the data
    always_ff @(posedge clk or posedge COUNTER)
    begin
        if (COUNTER)
        begin
            validMid <= 1'b0;
            validOut <= 1'b0;
        end
        else
        begin
            validMid <= stageIn.valid;
            validOut <= validMid;
        end
    end

    assign stageOut.valid = validOut;
    assign stageOut.state = stateReg;

endmodule

`default_nettype wire

//--- design/aes_core.sv
`timescale 1ns/10ps
`default_nettype none

`include "aes_cfg.svh"

module aes_core
(
    input  logic              clk,
    input  logic              COUNTER,
    input  logic              inValid,
    input  aesPkg::aesBlock_t plainText,
    input  aesPkg::aesBlock_t cipherKey,
    output logic              outValid,
    output aesPkg::aesBlock_t cipherText
);

    import aesPkg::*;

    aesBlock_t whiteState;
    aesBlock_t whiteKey;
    logic      whiteValid;

    // Entry i is the input of round stage i, the last one is the result
    aesStage_t stageChain [0:`AES_ROUNDS];

    // Key chain runs beside the state chain, two cycles per stage
    aesBlock_t keyChain [0:`AES_ROUNDS-1];
    aesBlock_t roundKeys [0:`AES_ROUNDS-1];

    //////////////////////////////
    // Input whitening
    //////////////////////////////

    // AddRoundKey with the cipher key itself
    always_ff @(posedge clk)
    begin
        whiteState <= plainText ^ cipherKey;
        whiteKey   <= cipherKey;
    end

    always_ff @(posedge clk or posedge COUNTER)
    begin
        if (COUNTER)
        begin
            whiteValid <= 1'b0;
        end
        else
        begin
            whiteValid <= inValid;
        end
    end

    assign stageChain[0].valid = whiteValid;
    assign stageChain[0].state = whiteState;
    assign keyChain[0] = whiteKey;

    //////////////////////////////
    // Round pipeline
    //////////////////////////////

    for (genvar i = 0; i < `AES_ROUNDS; i++)
    begin : gRound
        if (i < `AES_ROUNDS - 1)
        begin : gKey
            aes_key_stage #(
                .roundIdx(i + 1)
            ) uKeyStage (
                .clk     (clk),
                .prevKey (keyChain[i]),
                .roundKey(roundKeys[i]),
                .nextKey (keyChain[i+1])
            );
        end
        else
        begin : gKeyLast
            // No key stage follows the last one
            aes_key_stage #(
                .roundIdx(i + 1)
            ) uKeyStage (
                .clk     (clk),
                .prevKey (keyChain[i]),
                .roundKey(roundKeys[i]),
                .nextKey ()
            );
        end

        aes_round_stage #(
            .finalRound(i == `AES_ROUNDS - 1)
        ) uRoundStage (
            .clk     (clk),
            .COUNTER (COUNTER),
            .stageIn (stageChain[i]),
            .roundKey(roundKeys[i]),
            .stageOut(stageChain[i+1])
        );
    end

    assign outValid   = stageChain[`AES_ROUNDS].valid;
    assign cipherText = stageChain[`AES_ROUNDS].state;

endmodule

`default_nettype wire

//--- sim/aes_tb_assert.sv
`timescale 1ns/10ps
`default_nettype none

`include "aes_cfg.svh"

module aes_tb_assert
(
    input  logic              clk,
    input  logic              COUNTER,
    input  logic              inValid,
    input  logic              outValid,
    input  aesPkg::aesBlock_t cipherText
);

    // Read by the testbench top at the end of the run
    int unsigned failCount = 0;

    //////////////////////////////
    // Valid timing
    //////////////////////////////

    // Every accepted block leaves exactly one latency later
    latencyForward: assert property (
        @(posedge clk) disable iff (COUNTER)
        inValid |-> ##(`AES_LATENCY) outValid
    )
    else
    begin
        failCount++;
        $error("outValid missing %0d cycles after inValid", `AES_LATENCY);
    end

    // No result without a block one latency earlier
    latencyBackward: assert property (
        @(posedge clk) disable iff (COUNTER)
        outValid |-> $past(inValid, `AES_LATENCY)
    )
    else
    begin
        failCount++;
        $error("outValid high without inValid %0d cycles earlier", `AES_LATENCY);
    end

    //////////////////////////////
    // Reset and data
    //////////////////////////////

    resetClearsValid: assert property (
        @(posedge clk) COUNTER |-> !outValid
    )
    else
    begin
        failCount++;
        $error("outValid high while COUNTER is asserted");
    end

    validKnown: assert property (
        @(posedge clk) disable iff (COUNTER)
        !$isunknown(outValid)
    )
    else
    begin
        failCount++;
        $error("outValid is unknown outside reset");
    end

    cipherKnown: assert property (
        @(posedge clk) disable iff (COUNTER)
        outValid |-> !$isunknown(cipherText)
    )
    else
    begin
        failCount++;
        $error("cipherText has unknown bits while outValid is high");
    end

endmodule

bind aes_core aes_tb_assert uAesAssert (
    .clk       (clk),
    .COUNTER   (COUNTER),
    .inValid   (inValid),
    .outValid  (outValid),
    .cipherText(cipherText)
);

`default_nettype wire

//--- sim/aes_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "aes_cfg.svh"

module aes_tb;

    import aesPkg::*;

    localparam int resetCycles = 10;
    localparam int randBlocks  = 24;
    // Second reset then covers the cycles in which the dropped blocks would leave
    localparam int dropIdle    = 15;
    // Single vectors, back to back, random phase, recovery block
    localparam int expectedChecks = 3 + 3 + randBlocks + 1;

    logic      clk;
    logic      COUNTER;
    logic      inValid;
    aesBlock_t plainText;
    aesBlock_t cipherKey;
    logic      outValid;
    aesBlock_t cipherText;

    // FIPS-197 known answers
    aesBlock_t katPlain [3];
    aesBlock_t katKey [3];
    aesBlock_t katCipher [3];

    aesBlock_t expQueue [$];
    aesBlock_t expected;
    int        seed = 32'h6d3f_8846;
    int        gaps [randBlocks];
    int        picks [randBlocks];
    int        gapTotal;
    int        timeoutCycles = 0;
    int        checkCount = 0;
    int        valueErrors = 0;
    int        otherErrors = 0;
    int        assertErrors;

    aes_core u_aes_core (
        .clk       (clk),
        .COUNTER   (COUNTER),
        .inValid   (inValid),
        .plainText (plainText),
        .cipherKey (cipherKey),
        .outValid  (outValid),
        .cipherText(cipherText)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #4 clk = ~clk;
        end
    end

    //////////////////////////////
    // Result checker
    //////////////////////////////

    // Outputs are registered and seen here before this edge updates them
    always @(posedge clk)
    begin
        if (outValid)
        begin
            if (expQueue.size() == 0)
            begin
                otherErrors++;
                $display("outValid went high at %0t with no block in flight", $time);
            end
            else
            begin
                expected = expQueue.pop_front();
                checkCount++;
                assert (cipherText == expected)
                else
                begin
                    valueErrors++;
                    $display("Error at %0t: cipherText expected %h, got %h",
                             $time, expected, cipherText);
                end
            end
        end
    end

    initial
    begin
        wait (timeoutCycles != 0);
        repeat (timeoutCycles) @(posedge clk);
        $display("Timeout after %0d cycles, results stopped arriving", timeoutCycles);
        $display("SOME TESTS FAILED");
        $finish;
    end

    //////////////////////////////
    // Stimulus tasks
    //////////////////////////////

    // In-flight blocks are lost, so their expected results go too
    task automatic resetDut();
        COUNTER = 1'b1;
        inValid = 1'b0;
        expQueue.delete();
        repeat (resetCycles) @(negedge clk);
        COUNTER = 1'b0;
    endtask

    task automatic applyBlock(input int idx);
        inValid   = 1'b1;
        plainText = katPlain[idx];
        cipherKey = katKey[idx];
        expQueue.push_back(katCipher[idx]);
        @(negedge clk);
    endtask

    // Junk on the data bus while idle
    task automatic idleCycles(input int n);
        inValid   = 1'b0;
        plainText = {$random(seed), $random(seed), $random(seed), $random(seed)};
        repeat (n) @(negedge clk);
    endtask

    task automatic drainPipeline();
        inValid = 1'b0;
        while (expQueue.size() != 0)
        begin
            @(negedge clk);
        end
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial
    begin
        COUNTER   = 1'b1;
        inValid   = 1'b0;
        plainText = '0;
        cipherKey = '0;

        katPlain[0]  = 128'h00112233445566778899aabbccddeeff;
        katKey[0]    = 128'h000102030405060708090a0b0c0d0e0f;
        katCipher[0] = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
        katPlain[1]  = 128'h3243f6a8885a308d313198a2e0370734;
        katKey[1]    = 128'h2b7e151628aed2a6abf7158809cf4f3c;
        katCipher[1] = 128'h3925841d02dc09fbdc118597196a0b32;
        katPlain[2]  = 128'h00000000000000000000000000000000;
        katKey[2]    = 128'h00000000000000000000000000000000;
        katCipher[2] = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;

        gapTotal = 0;
        for (int i = 0; i < randBlocks; i++)
        begin
            gaps[i]  = $unsigned($random(seed)) % 4;
            picks[i] = $unsigned($random(seed)) % 3;
            gapTotal += gaps[i];
        end
        // Seven drains or long idles of at most one latency each plus slack
        timeoutCycles = randBlocks + gapTotal + 2 * resetCycles + dropIdle + 20
                        + 8 * `AES_LATENCY + 50;

        resetDut();
        idleCycles(4);

        // Known answers one at a time
        for (int v = 0; v < 3; v++)
        begin
            applyBlock(v);
            drainPipeline();
        end

        // Back to back with a new key every cycle
        applyBlock(0);
        applyBlock(1);
        applyBlock(2);
        drainPipeline();

        // Random gaps
        for (int i = 0; i < randBlocks; i++)
        begin
            idleCycles(gaps[i]);
            applyBlock(picks[i]);
        end
        drainPipeline();

        // Blocks dropped by a reset mid-flight must never show up
        applyBlock(0);
        applyBlock(1);
        applyBlock(2);
        idleCycles(dropIdle);
        resetDut();
        idleCycles(`AES_LATENCY + 5);

        // Core works again after the second reset
        applyBlock(1);
        drainPipeline();
        idleCycles(2);

        assertErrors = u_aes_core.uAesAssert.failCount;
        if (checkCount != expectedChecks)
        begin
            otherErrors++;
            $display("Only %0d of %0d results were checked", checkCount, expectedChecks);
        end
        $display("Checks: %0d, value errors: %0d, other errors: %0d, assertion failures: %0d",
                 checkCount, valueErrors, otherErrors, assertErrors);
        if (valueErrors + otherErrors + assertErrors == 0)
        begin
            $display("ALL TESTS PASSED");
        end
        else
        begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+design
design/aes_pkg.sv
design/aes_key_stage.sv
design/aes_round_stage.sv
design/aes_core.sv
sim/aes_tb_assert.sv
sim/aes_tb.sv

//--- Bender.yml
package:
  name: aes_core

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/aes_pkg.sv
      - design/aes_key_stage.sv
      - design/aes_round_stage.sv
      - design/aes_core.sv

  - target: simulation
    include_dirs:
      - design
    files:
      - sim/aes_tb_assert.sv
      - sim/aes_tb.sv
